//--- logic/scope_pkg.sv
// Shared definitions for the scope self-test subsystem
// Bus, sample and capture widths as vector typedefs
// Host address map with regions and register offsets
// Capture depth, pattern step and the bus decoder state enum

`default_nettype none

package scope_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [15:0] sample_t;
    typedef logic [3:0]  channel_t;
    typedef logic [11:0] index_t;
    typedef logic [15:0] period_t;
    typedef logic [7:0]  capture_ptr_t;

    localparam int CAPTURE_DEPTH = 256;

    // Upper address nibble selects the target block
    localparam logic [3:0] REGION_REGS    = 4'h0;
    localparam logic [3:0] REGION_CAPTURE = 4'h1;

    // Word offsets inside the register region
    localparam logic [11:0] REG_CTRL     = 12'h000;
    localparam logic [11:0] REG_PERIOD   = 12'h001;
    localparam logic [11:0] REG_CHANNELS = 12'h002;
    localparam logic [11:0] REG_STATUS   = 12'h003;

    // Added to the sample index once per channel number
    localparam int CHANNEL_STEP = 100;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_TARGET,
        WAIT_RELEASE
    } bus_state_t;

endpackage

`default_nettype wire

//--- logic/bus_decoder.sv
// Host bus decoder
// Four-phase req/ack handshake towards the host
// One-cycle strobes towards the register block and the capture memory

`timescale 1ns/1ns
`default_nettype none

module bus_decoder (
    input  wire logic              clock,
    input  wire logic              rst_n,
    input  wire logic              bus_req,
    input  wire logic              bus_we,
    input  wire scope_pkg::addr_t  bus_addr,
    input  wire scope_pkg::word_t  bus_wdata,
    output logic                   bus_ack,
    output scope_pkg::word_t       bus_rdata,
    output logic                   reg_req,
    output logic                   cap_req,
    output logic                   tgt_we,
    output scope_pkg::addr_t       tgt_addr,
    output scope_pkg::word_t       tgt_wdata,
    input  wire logic              reg_done,
    input  wire scope_pkg::word_t  reg_rdata,
    input  wire logic              cap_done,
    input  wire scope_pkg::word_t  cap_rdata
);

    scope_pkg::bus_state_t state;
    logic [3:0] region;
    logic       miss_req;
    logic       miss_done;

    assign region = bus_addr[15:12];

    // Unmapped accesses go through an internal strobe and done pair,
    // so every access sees the same latency
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= scope_pkg::IDLE;
            reg_req   <= 1'b0;
            cap_req   <= 1'b0;
            miss_req  <= 1'b0;
            miss_done <= 1'b0;
            bus_ack   <= 1'b0;
        end else begin
            reg_req   <= 1'b0;
            cap_req   <= 1'b0;
            miss_req  <= 1'b0;
            miss_done <= miss_req;
            case (state)
                scope_pkg::IDLE: begin
                    if (bus_req) begin
                        reg_req  <= (region == scope_pkg::REGION_REGS);
                        cap_req  <= (region == scope_pkg::REGION_CAPTURE);
                        miss_req <= (region != scope_pkg::REGION_REGS) &&
                                    (region != scope_pkg::REGION_CAPTURE);
                        state    <= scope_pkg::WAIT_TARGET;
                    end
                end
                scope_pkg::WAIT_TARGET: begin
                    if (reg_done || cap_done || miss_done) begin
                        bus_ack <= 1'b1;
                        state   <= scope_pkg::WAIT_RELEASE;
                    end
                end
                scope_pkg::WAIT_RELEASE: begin
                    if (!bus_req) begin
                        bus_ack <= 1'b0;
                        state   <= scope_pkg::IDLE;
                    end
                end
                default: state <= scope_pkg::IDLE;
            endcase
        end
    end

    // Access payload is captured once per request
    always_ff @(posedge clock) begin
        if (state == scope_pkg::IDLE && bus_req) begin
            tgt_we    <= bus_we;
            tgt_addr  <= bus_addr;
            tgt_wdata <= bus_wdata;
        end
        if (state == scope_pkg::WAIT_TARGET) begin
            if (reg_done) begin
                bus_rdata <= reg_rdata;
            end else if (cap_done) begin
                bus_rdata <= cap_rdata;
            end else if (miss_done) begin
                bus_rdata <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/control_regs.sv
// Configuration and status registers
// Control with enable and rearm, sample period, channel count
// Read-only status built from the capture done flag and word count
// Rearm and sequence restart pulses

`timescale 1ns/1ns
`default_nettype none

module control_regs (
    input  wire logic                     clock,
    input  wire logic                     rst_n,
    input  wire logic                     req,
    input  wire logic                     we,
    input  wire scope_pkg::addr_t         addr,
    input  wire scope_pkg::word_t         wdata,
    output logic                          done,
    output scope_pkg::word_t              rdata,
    output logic                          enable,
    output scope_pkg::period_t            period,
    output scope_pkg::channel_t           channels,
    output logic                          rearm,
    output logic                          restart,
    input  wire logic                     capture_done,
    input  wire scope_pkg::capture_ptr_t  capture_count
);

    logic [11:0]         offset;
    scope_pkg::word_t    status_word;
    scope_pkg::channel_t channels_wr;

    assign offset = addr[11:0];

    assign status_word = {16'h0000, capture_count, 7'b0000000, capture_done};

    // A zero channel count would stall the pattern, so it becomes one
    assign channels_wr = (wdata[3:0] == 4'd0) ? 4'd1 : wdata[3:0];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            done     <= 1'b0;
            enable   <= 1'b0;
            period   <= '0;
            channels <= 4'd1;
            rearm    <= 1'b0;
            restart  <= 1'b0;
        end else begin
            done    <= req;
            rearm   <= 1'b0;
            restart <= 1'b0;
            if (req && we) begin
                case (offset)
                    scope_pkg::REG_CTRL: begin
                        enable <= wdata[0];
                        rearm  <= wdata[1];
                    end
                    scope_pkg::REG_PERIOD: begin
                        period <= wdata[15:0];
                    end
                    scope_pkg::REG_CHANNELS: begin
                        channels <= channels_wr;
                        restart  <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Read data follows the strobed offset
    always_ff @(posedge clock) begin
        if (req) begin
            case (offset)
                scope_pkg::REG_CTRL:     rdata <= {31'd0, enable};
                scope_pkg::REG_PERIOD:   rdata <= {16'h0000, period};
                scope_pkg::REG_CHANNELS: rdata <= {28'd0, channels};
                scope_pkg::REG_STATUS:   rdata <= status_word;
                default:                 rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/sample_timebase.sv
// Programmable sampling timebase
// Down-counter reloaded from the period register, one tick per period+1 cycles

`timescale 1ns/1ns
`default_nettype none

module sample_timebase (
    input  wire logic                clock,
    input  wire logic                rst_n,
    input  wire logic                enable,
    input  wire scope_pkg::period_t  period,
    output logic                     tick
);

    scope_pkg::period_t count;
    logic               tick_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count  <= '0;
            tick_q <= 1'b0;
        end else if (!enable) begin
            // Preload so the first tick lands period+1 cycles after enable
            count  <= period;
            tick_q <= 1'b0;
        end else if (count == '0) begin
            count  <= period;
            tick_q <= 1'b1;
        end else begin
            count  <= count - 1'b1;
            tick_q <= 1'b0;
        end
    end

    // A pending tick is dropped as soon as enable goes low
    assign tick = tick_q && enable;

endmodule

`default_nettype wire

//--- logic/pattern_source.sv
// Synthetic multi-channel sample generator
// Walks through the channels on each tick, index advances after the last channel
// Sample value is index plus a fixed step per channel number

`timescale 1ns/1ns
`default_nettype none

module pattern_source (
    input  wire logic                 clock,
    input  wire logic                 rst_n,
    input  wire logic                 tick,
    input  wire scope_pkg::channel_t  channels,
    input  wire logic                 restart,
    output logic                      sample_valid,
    output scope_pkg::sample_t        sample_data,
    output scope_pkg::channel_t       sample_channel
);

    scope_pkg::channel_t channel;
    scope_pkg::index_t   index;
    scope_pkg::sample_t  value;
    logic                last_channel;

    assign value = scope_pkg::sample_t'(index) +
                   scope_pkg::sample_t'(scope_pkg::CHANNEL_STEP * channel);

    // Compare with >= so a lowered channel count still wraps
    assign last_channel = (channel >= channels - 4'd1);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            channel      <= '0;
            index        <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= tick && !restart;
            if (restart) begin
                channel <= '0;
                index   <= '0;
            end else if (tick) begin
                if (last_channel) begin
                    channel <= '0;
                    index   <= index + 1'b1;
                end else begin
                    channel <= channel + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (tick) begin
            sample_data    <= value;
            sample_channel <= channel;
        end
    end

endmodule

`default_nettype wire

//--- logic/capture_buffer.sv
// Capture memory for the sample stream
// Write pointer, done flag and captured-word count
// Host read port with a one-cycle answer

`timescale 1ns/1ns
`default_nettype none

module capture_buffer (
    input  wire logic                 clock,
    input  wire logic                 rst_n,
    input  wire logic                 sample_valid,
    input  wire scope_pkg::sample_t   sample_data,
    input  wire scope_pkg::channel_t  sample_channel,
    input  wire logic                 rearm,
    output logic                      capture_done,
    output scope_pkg::capture_ptr_t   capture_count,
    input  wire logic                 req,
    input  wire scope_pkg::addr_t     addr,
    output logic                      done,
    output scope_pkg::word_t          rdata
);

    scope_pkg::word_t        mem [scope_pkg::CAPTURE_DEPTH];
    scope_pkg::capture_ptr_t wr_ptr;
    scope_pkg::capture_ptr_t rd_ptr;
    scope_pkg::word_t        sample_word;
    logic                    write_en;

    assign sample_word = {12'h000, sample_channel, sample_data};

    // Once full, further samples are dropped
    assign write_en = sample_valid && !capture_done && !rearm;

    assign rd_ptr = addr[7:0];

    assign capture_count = wr_ptr;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            capture_done <= 1'b0;
            done         <= 1'b0;
        end else begin
            done <= req;
            if (rearm) begin
                wr_ptr       <= '0;
                capture_done <= 1'b0;
            end else if (write_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                // The pointer wraps to 0 on the last write, the flag marks full
                if (wr_ptr == scope_pkg::capture_ptr_t'(scope_pkg::CAPTURE_DEPTH - 1)) begin
                    capture_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write_en) begin
            mem[wr_ptr] <= sample_word;
        end
    end

    // Host writes into this region only get the done strobe
    always_ff @(posedge clock) begin
        if (req) begin
            rdata <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- logic/scope_test_top.sv
// Top level of the scope self-test subsystem
// Bus decoder, register block, timebase, pattern source and capture memory

`timescale 1ns/1ns
`default_nettype none

module scope_test_top (
    input  wire logic              clock,
    input  wire logic              rst_n,
    input  wire logic              bus_req,
    input  wire logic              bus_we,
    input  wire scope_pkg::addr_t  bus_addr,
    input  wire scope_pkg::word_t  bus_wdata,
    output logic                   bus_ack,
    output scope_pkg::word_t       bus_rdata,
    output logic                   capture_done
);

    logic                    reg_req;
    logic                    cap_req;
    logic                    tgt_we;
    scope_pkg::addr_t        tgt_addr;
    scope_pkg::word_t        tgt_wdata;
    logic                    reg_done;
    scope_pkg::word_t        reg_rdata;
    logic                    cap_done;
    scope_pkg::word_t        cap_rdata;

    logic                    enable;
    scope_pkg::period_t      period;
    scope_pkg::channel_t     channels;
    logic                    rearm;
    logic                    restart;
    logic                    tick;
    logic                    sample_valid;
    scope_pkg::sample_t      sample_data;
    scope_pkg::channel_t     sample_channel;
    scope_pkg::capture_ptr_t capture_count;

    bus_decoder decoder0 (
        .clock     (clock),
        .rst_n     (rst_n),
        .bus_req   (bus_req),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata),
        .reg_req   (reg_req),
        .cap_req   (cap_req),
        .tgt_we    (tgt_we),
        .tgt_addr  (tgt_addr),
        .tgt_wdata (tgt_wdata),
        .reg_done  (reg_done),
        .reg_rdata (reg_rdata),
        .cap_done  (cap_done),
        .cap_rdata (cap_rdata)
    );

    control_regs regs0 (
        .clock         (clock),
        .rst_n         (rst_n),
        .req           (reg_req),
        .we            (tgt_we),
        .addr          (tgt_addr),
        .wdata         (tgt_wdata),
        .done          (reg_done),
        .rdata         (reg_rdata),
        .enable        (enable),
        .period        (period),
        .channels      (channels),
        .rearm         (rearm),
        .restart       (restart),
        .capture_done  (capture_done),
        .capture_count (capture_count)
    );

    sample_timebase timebase0 (
        .clock  (clock),
        .rst_n  (rst_n),
        .enable (enable),
        .period (period),
        .tick   (tick)
    );

    pattern_source pattern0 (
        .clock          (clock),
        .rst_n          (rst_n),
        .tick           (tick),
        .channels       (channels),
        .restart        (restart),
        .sample_valid   (sample_valid),
        .sample_data    (sample_data),
        .sample_channel (sample_channel)
    );

    capture_buffer capture0 (
        .clock          (clock),
        .rst_n          (rst_n),
        .sample_valid   (sample_valid),
        .sample_data    (sample_data),
        .sample_channel (sample_channel),
        .rearm          (rearm),
        .capture_done   (capture_done),
        .capture_count  (capture_count),
        .req            (cap_req),
        .addr           (tgt_addr),
        .done           (cap_done),
        .rdata          (cap_rdata)
    );

endmodule

`default_nettype wire

//--- test/scope_test_assertions.sv
// Concurrent checks on the four-phase host handshake
// Capture done flag may only drop after a rearm
// Bound into the subsystem top level

`timescale 1ns/1ns
`default_nettype none

module scope_test_assertions (
    input wire logic clock,
    input wire logic rst_n,
    input wire logic bus_req,
    input wire logic bus_ack,
    input wire logic rearm,
    input wire logic capture_done
);

    // Ack answers a request that was present on the edge before
    assert property (@(posedge clock) disable iff (!rst_n)
        $rose(bus_ack) |-> $past(bus_req))
        else $error("bus_ack rose without bus_req");

    assert property (@(posedge clock) disable iff (!rst_n)
        (bus_ack && bus_req) |=> bus_ack)
        else $error("bus_ack dropped while bus_req was still high");

    // The host may drop req in the same cycle that ack shows up
    assert property (@(posedge clock) disable iff (!rst_n)
        (bus_req && !bus_ack) |=> (bus_req || bus_ack))
        else $error("bus_req dropped before bus_ack rose");

    assert property (@(posedge clock) disable iff (!rst_n)
        $fell(capture_done) |-> $past(rearm))
        else $error("capture_done fell without a rearm");

endmodule

bind scope_test_top scope_test_assertions asrt0 (
    .clock        (clock),
    .rst_n        (rst_n),
    .bus_req      (bus_req),
    .bus_ack      (bus_ack),
    .rearm        (rearm),
    .capture_done (capture_done)
);

`default_nettype wire

//--- test/scope_test_tb.sv
// Testbench for the scope self-test subsystem
// Four-phase bus driver, step table with its runner and a capture reference
// Cycle limit on the whole run and a closing summary

`timescale 1ns/1ns
`default_nettype none

module scope_test_tb;

    localparam int unsigned RANDOM_SEED = 14170;
    localparam int CYCLES_PER_STEP = 256 * 16 * 4;
    localparam int TIMEOUT_MARGIN = 10000;
    localparam logic [31:0] ALL_BITS = 32'hFFFF_FFFF;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_WAIT_DONE,
        OP_CHECK_CAPTURE,
        OP_IDLE
    } op_t;

    // For OP_CHECK_CAPTURE data is the channel count, for OP_IDLE the cycle count
    typedef struct packed {
        op_t              op;
        scope_pkg::addr_t addr;
        scope_pkg::word_t data;
        scope_pkg::word_t expected;
        scope_pkg::word_t mask;
    } step_t;

    logic             clock;
    logic             rst_n;
    logic             bus_req;
    logic             bus_we;
    scope_pkg::addr_t bus_addr;
    scope_pkg::word_t bus_wdata;
    logic             bus_ack;
    scope_pkg::word_t bus_rdata;
    logic             capture_done;

    step_t steps[$];
    int    error_count = 0;
    int    steps_passed = 0;
    int    steps_failed = 0;
    int    cycle_count = 0;
    int    cycle_limit = 0;
    int    first_period;
    int    first_channels;
    int    second_period;
    int    second_channels;

    scope_test_top dut0 (
        .clock        (clock),
        .rst_n        (rst_n),
        .bus_req      (bus_req),
        .bus_we       (bus_we),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .bus_ack      (bus_ack),
        .bus_rdata    (bus_rdata),
        .capture_done (capture_done)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    function automatic scope_pkg::addr_t reg_addr(input logic [11:0] offset);
        return {scope_pkg::REGION_REGS, offset};
    endfunction

    function automatic scope_pkg::addr_t cap_addr(input int k);
        return {scope_pkg::REGION_CAPTURE, 4'h0, 8'(k)};
    endfunction

    // Word k holds channel k mod n and sample floor(k/n) plus the channel step
    function automatic scope_pkg::word_t expected_capture(input int k, input int channels);
        int          ch;
        int          idx;
        logic [15:0] value;
        ch    = k % channels;
        idx   = k / channels;
        value = 16'(idx + scope_pkg::CHANNEL_STEP * ch);
        return {12'h000, 4'(ch), value};
    endfunction

    function automatic string op_name(input op_t op);
        case (op)
            OP_WRITE:         return "write";
            OP_READ:          return "read";
            OP_WAIT_DONE:     return "wait-done";
            OP_CHECK_CAPTURE: return "check-capture";
            default:          return "idle";
        endcase
    endfunction

    // Called and left 2 ns after a rising edge
    task automatic bus_cycle(input logic we, input scope_pkg::addr_t addr,
                             input scope_pkg::word_t wdata, output scope_pkg::word_t rdata);
        bus_req   = 1'b1;
        bus_we    = we;
        bus_addr  = addr;
        bus_wdata = wdata;
        @(posedge clock);
        #2;
        while (!bus_ack) begin
            @(posedge clock);
            #2;
        end
        // Req stays up one more cycle while ack and rdata hold their values
        @(posedge clock);
        #2;
        rdata   = bus_rdata;
        bus_req = 1'b0;
        while (bus_ack) begin
            @(posedge clock);
            #2;
        end
    endtask

    task automatic check_word(input string name, input scope_pkg::word_t expected,
                              input scope_pkg::word_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s expected 0x%08h actual 0x%08h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic add_step(input op_t op, input scope_pkg::addr_t addr,
                            input scope_pkg::word_t data, input scope_pkg::word_t expected,
                            input scope_pkg::word_t mask);
        step_t step;
        step.op       = op;
        step.addr     = addr;
        step.data     = data;
        step.expected = expected;
        step.mask     = mask;
        steps.push_back(step);
    endtask

    task automatic build_table();
        // Register access
        add_step(OP_WRITE, reg_addr(scope_pkg::REG_PERIOD), 32'h0000_1234, 0, 0);
        add_step(OP_READ, reg_addr(scope_pkg::REG_PERIOD), 0, 32'h0000_1234, ALL_BITS);
        add_step(OP_WRITE, reg_addr(scope_pkg::REG_CHANNELS), 32'd7, 0, 0);
        add_step(OP_READ, reg_addr(scope_pkg::REG_CHANNELS), 0, 32'd7, ALL_BITS);
        add_step(OP_WRITE, reg_addr(scope_pkg::REG_CHANNELS), 32'd0, 0, 0);
        add_step(OP_READ, reg_addr(scope_pkg::REG_CHANNELS), 0, 32'd1, ALL_BITS);
        add_step(OP_WRITE, reg_addr(scope_pkg::REG_CTRL), 32'd3, 0, 0);
        add_step(OP_READ, reg_addr(scope_pkg::REG_CTRL), 0, 32'd1, ALL_BITS);
        add_step(OP_WRITE, reg_addr(scope_pkg::REG_CTRL), 32'd0, 0, 0);
        add_step(OP_READ, reg_addr(scope_pkg::REG_CTRL), 0, 32'd0, ALL_BITS);
        add_step(OP_READ, 16'h2040, 0, 32'd0, ALL_BITS);
        // Unmapped write whose low bits match the period offset
        add_step(OP_WRITE, 16'h4001, 32'hDEAD_BEEF, 0, 0);
        add_step(OP_READ, reg_addr(scope_pkg::REG_PERIOD), 0, 32'h0000_1234, ALL_BITS);
        // First capture with random settings
        add_step(OP_WRITE, reg_addr(scope_pkg::REG_PERIOD), first_period, 0, 0);
        add_step(OP_WRITE, reg_addr(scope_pkg::REG_CHANNELS), first_channels, 0, 0);
        add_step(OP_WRITE, reg_addr(scope_pkg::REG_CTRL), 32'd1, 0, 0);
        add_step(OP_WAIT_DONE, 0, 0, 0, 0);
        add_step(OP_CHECK_CAPTURE, 0, first_channels, 0, 0);
        // Full buffer keeps its contents while ticks go on
        add_step(OP_READ, reg_addr(scope_pkg::REG_STATUS), 0, 32'h0000_0001, ALL_BITS);
        add_step(OP_IDLE, 0, 300, 32'd1, 0);
        add_step(OP_CHECK_CAPTURE, 0, first_channels, 0, 0);
        // Rearm with new settings and a restarted sequence
        add_step(OP_WRITE, reg_addr(scope_pkg::REG_CTRL), 32'd0, 0, 0);
        add_step(OP_WRITE, reg_addr(scope_pkg::REG_PERIOD), second_period, 0, 0);
        add_step(OP_WRITE, reg_addr(scope_pkg::REG_CHANNELS), second_channels, 0, 0);
        add_step(OP_WRITE, reg_addr(scope_pkg::REG_CTRL), 32'd3, 0, 0);
        add_step(OP_READ, reg_addr(scope_pkg::REG_STATUS), 0, 32'd0, 32'd1);
        add_step(OP_WAIT_DONE, 0, 0, 0, 0);
        add_step(OP_CHECK_CAPTURE, 0, second_channels, 0, 0);
        // Rearm while disabled and check that nothing is captured
        add_step(OP_WRITE, reg_addr(scope_pkg::REG_CTRL), 32'd2, 0, 0);
        add_step(OP_READ, reg_addr(scope_pkg::REG_STATUS), 0, 32'd0, ALL_BITS);
        add_step(OP_IDLE, 0, 2000, 32'd0, 0);
        add_step(OP_READ, reg_addr(scope_pkg::REG_STATUS), 0, 32'd0, ALL_BITS);
    endtask

    task automatic run_step(input int number, input step_t step);
        scope_pkg::word_t rdata;
        int               errors_before;
        int               k;
        errors_before = error_count;
        case (step.op)
            OP_WRITE: begin
                bus_cycle(1'b1, step.addr, step.data, rdata);
            end
            OP_READ: begin
                bus_cycle(1'b0, step.addr, '0, rdata);
                check_word($sformatf("bus_rdata[0x%04h]", step.addr),
                           step.expected & step.mask, rdata & step.mask);
            end
            OP_WAIT_DONE: begin
                while (!capture_done) begin
                    @(posedge clock);
                    #2;
                end
            end
            OP_CHECK_CAPTURE: begin
                for (k = 0; k < scope_pkg::CAPTURE_DEPTH; k++) begin
                    bus_cycle(1'b0, cap_addr(k), '0, rdata);
                    check_word($sformatf("bus_rdata[0x%04h]", cap_addr(k)),
                               expected_capture(k, int'(step.data)), rdata);
                end
            end
            default: begin
                // The done output must hold its level for the whole wait
                for (k = 0; k < int'(step.data); k++) begin
                    @(posedge clock);
                    #2;
                    check_word("capture_done", {31'd0, step.expected[0]}, {31'd0, capture_done});
                    if (error_count != errors_before) begin
                        break;
                    end
                end
            end
        endcase
        if (error_count == errors_before) begin
            steps_passed++;
            $display("step %0d %s 0x%04h ok", number, op_name(step.op), step.addr);
        end else begin
            steps_failed++;
            $display("step %0d %s 0x%04h FAILED", number, op_name(step.op), step.addr);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        bus_req   = 1'b0;
        bus_we    = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        void'($urandom(RANDOM_SEED));
        first_period    = int'($urandom % 4);
        first_channels  = 1 + int'($urandom % 15);
        second_period   = int'($urandom % 4);
        second_channels = 1 + int'($urandom % 15);
        if (second_channels == first_channels) begin
            second_channels = (first_channels % 15) + 1;
        end
        build_table();
        cycle_limit = steps.size() * CYCLES_PER_STEP + TIMEOUT_MARGIN;
        repeat (16) @(posedge clock);
        #2;
        rst_n = 1'b1;
        @(posedge clock);
        #2;
        for (int i = 0; i < steps.size(); i++) begin
            run_step(i, steps[i]);
        end
        $display("Steps run %0d, passed %0d, failed %0d, errors %0d",
                 steps.size(), steps_passed, steps_failed, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
logic/scope_pkg.sv
logic/bus_decoder.sv
logic/control_regs.sv
logic/sample_timebase.sv
logic/pattern_source.sv
logic/capture_buffer.sv
logic/scope_test_top.sv
test/scope_test_assertions.sv
test/scope_test_tb.sv

//--- Makefile
# Verilator build and run for the scope self-test subsystem

VERILATOR ?= verilator
TOP       ?= scope_test_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Everything OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, so the simulator status is not used here
run: compile
	-./$(BINARY) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
